// File: filelist.f
+incdir+hw
hw/aether_pkg.sv
hw/aether_cmd_capture.sv
hw/aether_engine_decoder.sv
hw/aether_register_file.sv
hw/aether_engine_ctrl_top.sv
tb/aether_tb.sv

// File: hw/aether_cmd_capture.sv
`timescale 1ns/1ns

`include "aether_consts.svh"

module aether_cmd_capture (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        cmd_valid_i,
  input  logic [`AETHER_INSTR_W-1:0]  instr_i,
  input  logic [`AETHER_PARAM1_W-1:0] param_1_i,
  input  logic [`AETHER_PARAM2_W-1:0] param_2_i,
  input  logic [`AETHER_PARAM2_W-1:0] rd_data_i,
  input  logic                        rd_hit_i,
  output aether_pkg::cmd_t            cmd_o,
  output logic                        cmd_live_o,
  output logic [`AETHER_PARAM2_W-1:0] rdata_o,
  output logic                        rdata_valid_o
);

  // ----------------------------------------------------------------------
  // Command register
  // ----------------------------------------------------------------------

  // Payload only, qualified downstream by cmd_live_o
  always_ff @(posedge clk_i)
  begin
    if (cmd_valid_i)
    begin
      cmd_o.instr   <= aether_pkg::instr_e'(instr_i);
      cmd_o.param_1 <= param_1_i;
      cmd_o.param_2 <= param_2_i;
    end
  end

  // Live for exactly the cycle after the strobe
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      cmd_live_o <= 1'b0;
    else
      cmd_live_o <= cmd_valid_i;
  end

  // ----------------------------------------------------------------------
  // Readback register
  // ----------------------------------------------------------------------

  // Holds last read value until the next read hit
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rdata_o       <= '0;
      rdata_valid_o <= 1'b0;
    end
    else
    begin
      rdata_valid_o <= rd_hit_i;
      if (rd_hit_i)
        rdata_o <= rd_data_i;
    end
  end

endmodule

// File: hw/aether_consts.svh
`ifndef AETHER_CONSTS_SVH
`define AETHER_CONSTS_SVH

// ----------------------------------------------------------------------
// Instruction word fields
// ----------------------------------------------------------------------

// Opcode field
`define AETHER_INSTR_W 4

// Sub-command or register selector
`define AETHER_PARAM1_W 4

// Immediate, also the register data width
`define AETHER_PARAM2_W 16

// Save address is param_1 on top of param_2
`define AETHER_SAVE_ADDR_W 20

// ----------------------------------------------------------------------
// Identity registers, read only
// ----------------------------------------------------------------------

`define AETHER_VERSN_VALUE 16'h0102
`define AETHER_HWRID_VALUE 16'hAE01

`endif

// File: hw/aether_engine_ctrl_top.sv
`timescale 1ns/1ns

`include "aether_consts.svh"

module aether_engine_ctrl_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        cmd_valid_i,
  input  logic [`AETHER_INSTR_W-1:0]  instr_i,
  input  logic [`AETHER_PARAM1_W-1:0] param_1_i,
  input  logic [`AETHER_PARAM2_W-1:0] param_2_i,
  output logic [`AETHER_PARAM2_W-1:0] rdata_o,
  output logic                        rdata_valid_o,
  output aether_pkg::rst_cmd_t        rst_o,
  output aether_pkg::ldw_cmd_t        ldw_o,
  output aether_pkg::run_cmd_t        cnv_o,
  output aether_pkg::run_cmd_t        dns_o,
  output aether_pkg::lip_cmd_t        lip_o,
  output aether_pkg::mem_cmd_e        mem_cmd_o,
  output logic                        cmd_err_o
);

  // Capture to decoder
  aether_pkg::cmd_t            cmd;
  logic                        cmd_live;

  // Decoder to register file and back
  aether_pkg::reg_addr_e       rd_sel;
  logic [`AETHER_PARAM2_W-1:0] rf_rd_data;
  logic [`AETHER_PARAM2_W-1:0] rd_data;
  logic                        rd_hit;
  aether_pkg::reg_wr_t         reg_wr;
  logic                        reg_clear;

  // Bank clears on either register or full reset
  assign reg_clear = rst_o.regs | rst_o.full;

  aether_cmd_capture u_capture (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cmd_valid_i   (cmd_valid_i),
    .instr_i       (instr_i),
    .param_1_i     (param_1_i),
    .param_2_i     (param_2_i),
    .rd_data_i     (rd_data),
    .rd_hit_i      (rd_hit),
    .cmd_o         (cmd),
    .cmd_live_o    (cmd_live),
    .rdata_o       (rdata_o),
    .rdata_valid_o (rdata_valid_o)
  );

  aether_engine_decoder u_decoder (
    .cmd_i      (cmd),
    .cmd_live_i (cmd_live),
    .rd_data_i  (rf_rd_data),
    .rd_sel_o   (rd_sel),
    .rd_data_o  (rd_data),
    .rd_hit_o   (rd_hit),
    .reg_wr_o   (reg_wr),
    .rst_o      (rst_o),
    .ldw_o      (ldw_o),
    .cnv_o      (cnv_o),
    .dns_o      (dns_o),
    .lip_o      (lip_o),
    .mem_cmd_o  (mem_cmd_o),
    .cmd_err_o  (cmd_err_o)
  );

  aether_register_file u_regs (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .reg_wr_i  (reg_wr),
    .rd_sel_i  (rd_sel),
    .clear_i   (reg_clear),
    .err_i     (cmd_err_o),
    .rd_data_o (rf_rd_data)
  );

endmodule

// File: hw/aether_engine_decoder.sv
`timescale 1ns/1ns

`include "aether_consts.svh"

module aether_engine_decoder (
  input  aether_pkg::cmd_t            cmd_i,
  input  logic                        cmd_live_i,
  input  logic [`AETHER_PARAM2_W-1:0] rd_data_i,
  output aether_pkg::reg_addr_e       rd_sel_o,
  output logic [`AETHER_PARAM2_W-1:0] rd_data_o,
  output logic                        rd_hit_o,
  output aether_pkg::reg_wr_t         reg_wr_o,
  output aether_pkg::rst_cmd_t        rst_o,
  output aether_pkg::ldw_cmd_t        ldw_o,
  output aether_pkg::run_cmd_t        cnv_o,
  output aether_pkg::run_cmd_t        dns_o,
  output aether_pkg::lip_cmd_t        lip_o,
  output aether_pkg::mem_cmd_e        mem_cmd_o,
  output logic                        cmd_err_o
);

  // Opcode hits, all qualified by the live flag
  logic is_rst;
  logic is_rdr;
  logic is_wrr;
  logic is_ldw;
  logic is_cnv;
  logic is_dns;
  logic is_lip;

  // Per-section illegal command flags
  logic rst_err;
  logic rdr_err;
  logic wrr_err;
  logic ldw_err;
  logic dns_err;
  logic lip_err;

  // LDW memory requests
  logic ldw_mem_read;
  logic ldw_mem_write;

  assign is_rst = cmd_live_i && (cmd_i.instr == aether_pkg::RST);
  assign is_rdr = cmd_live_i && (cmd_i.instr == aether_pkg::RDR);
  assign is_wrr = cmd_live_i && (cmd_i.instr == aether_pkg::WRR);
  assign is_ldw = cmd_live_i && (cmd_i.instr == aether_pkg::LDW);
  assign is_cnv = cmd_live_i && (cmd_i.instr == aether_pkg::CNV);
  assign is_dns = cmd_live_i && (cmd_i.instr == aether_pkg::DNS);
  assign is_lip = cmd_live_i && (cmd_i.instr == aether_pkg::LIP);

  // NOP and opcodes 8 to 15 hit no section below

  // ----------------------------------------------------------------------
  // RST
  // ----------------------------------------------------------------------

  always_comb
  begin
    rst_o   = '0;
    rst_err = 1'b0;
    if (is_rst)
    begin
      case (cmd_i.param_1)
        aether_pkg::RST_FULL: rst_o = '1;
        aether_pkg::RST_CWGT: rst_o.cwgt = 1'b1;
        aether_pkg::RST_CONV: rst_o.conv = 1'b1;
        aether_pkg::RST_DWGT: rst_o.dwgt = 1'b1;
        aether_pkg::RST_DENS: rst_o.dens = 1'b1;
        aether_pkg::RST_REGS: rst_o.regs = 1'b1;
        default:
        begin
          // Unknown code falls back to full reset
          rst_o   = '1;
          rst_err = 1'b1;
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // RDR
  // ----------------------------------------------------------------------

  always_comb
  begin
    rd_sel_o  = aether_pkg::REG_VERSN;
    rd_data_o = '0;
    rd_hit_o  = 1'b0;
    rdr_err   = 1'b0;
    if (is_rdr)
    begin
      rd_sel_o = aether_pkg::reg_addr_e'(cmd_i.param_1);
      // Read still returns, as zero when unknown
      rd_hit_o = 1'b1;
      if (cmd_i.param_1 <= aether_pkg::REG_STATS)
        rd_data_o = rd_data_i;
      else
        rdr_err = 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // WRR
  // ----------------------------------------------------------------------

  always_comb
  begin
    reg_wr_o = '0;
    wrr_err  = 1'b0;
    if (is_wrr)
    begin
      case (cmd_i.param_1)
        // Identity registers
        aether_pkg::REG_VERSN,
        aether_pkg::REG_HWRID: wrr_err = 1'b1;
        aether_pkg::REG_MEMUP,
        aether_pkg::REG_MSTRT,
        aether_pkg::REG_MENDD,
        aether_pkg::REG_BCFG1,
        aether_pkg::REG_BCFG2,
        aether_pkg::REG_BCFG3,
        aether_pkg::REG_CPRM1,
        aether_pkg::REG_STATS:
        begin
          reg_wr_o.we   = 1'b1;
          reg_wr_o.addr = aether_pkg::reg_addr_e'(cmd_i.param_1);
          reg_wr_o.data = cmd_i.param_2;
        end
        default: wrr_err = 1'b1;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // LDW
  // ----------------------------------------------------------------------

  always_comb
  begin
    ldw_o         = '0;
    ldw_mem_read  = 1'b0;
    ldw_mem_write = 1'b0;
    ldw_err       = 1'b0;
    if (is_ldw)
    begin
      case (cmd_i.param_1)
        aether_pkg::LDW_CWGT:
        begin
          ldw_o.cwgt   = 1'b1;
          ldw_mem_read = 1'b1;
        end
        aether_pkg::LDW_DWGT:
        begin
          ldw_o.dwgt   = 1'b1;
          ldw_mem_read = 1'b1;
        end
        aether_pkg::LDW_STRT: ldw_o.strt = 1'b1;
        aether_pkg::LDW_CONT: ldw_o.cont = 1'b1;
        aether_pkg::LDW_MOVE:
        begin
          // Move pushes weights back to memory
          ldw_o.move    = 1'b1;
          ldw_mem_write = 1'b1;
        end
        default: ldw_err = 1'b1;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // CNV
  // ----------------------------------------------------------------------

  always_comb
  begin
    cnv_o = '0;
    if (is_cnv)
    begin
      cnv_o.run       = 1'b1;
      cnv_o.save_addr = {cmd_i.param_1, cmd_i.param_2};
    end
  end

  // ----------------------------------------------------------------------
  // DNS
  // ----------------------------------------------------------------------

  always_comb
  begin
    dns_o   = '0;
    dns_err = 1'b0;
    if (is_dns)
    begin
      // Only sub-command 0 runs
      if (cmd_i.param_1 == '0)
      begin
        dns_o.run       = 1'b1;
        dns_o.save_addr = {cmd_i.param_1, cmd_i.param_2};
      end
      else
        dns_err = 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // LIP
  // ----------------------------------------------------------------------

  always_comb
  begin
    lip_o   = '0;
    lip_err = 1'b0;
    if (is_lip)
    begin
      case (cmd_i.param_1)
        aether_pkg::LIP_STRT: lip_o.strt = 1'b1;
        aether_pkg::LIP_CONT: lip_o.cont = 1'b1;
        default: lip_err = 1'b1;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Memory command and error pulse
  // ----------------------------------------------------------------------

  // Write has priority, any CNV or DNS reads
  always_comb
  begin
    if (ldw_mem_write)
      mem_cmd_o = aether_pkg::MEM_WRITE;
    else if (ldw_mem_read || is_cnv || is_dns)
      mem_cmd_o = aether_pkg::MEM_READ;
    else
      mem_cmd_o = aether_pkg::MEM_IDLE;
  end

  assign cmd_err_o = rst_err | rdr_err | wrr_err | ldw_err | dns_err | lip_err;

endmodule

// File: hw/aether_pkg.sv
package aether_pkg;

`include "aether_consts.svh"

  // Opcodes, 8 to 15 unused
  typedef enum logic [`AETHER_INSTR_W-1:0] {
    NOP = 4'd0,
    RST = 4'd1,
    RDR = 4'd2,
    WRR = 4'd3,
    LDW = 4'd4,
    CNV = 4'd5,
    DNS = 4'd6,
    LIP = 4'd7
  } instr_e;

  // RST sub-commands
  typedef enum logic [`AETHER_PARAM1_W-1:0] {
    RST_FULL = 4'd0,
    RST_CWGT = 4'd1,
    RST_CONV = 4'd2,
    RST_DWGT = 4'd3,
    RST_DENS = 4'd4,
    RST_REGS = 4'd5
  } rst_sel_e;

  // Register map, VERSN and HWRID are constants
  typedef enum logic [`AETHER_PARAM1_W-1:0] {
    REG_VERSN = 4'd0,
    REG_HWRID = 4'd1,
    REG_MEMUP = 4'd2,
    REG_MSTRT = 4'd3,
    REG_MENDD = 4'd4,
    REG_BCFG1 = 4'd5,
    REG_BCFG2 = 4'd6,
    REG_BCFG3 = 4'd7,
    REG_CPRM1 = 4'd8,
    REG_STATS = 4'd9
  } reg_addr_e;

  // LDW sub-commands
  typedef enum logic [`AETHER_PARAM1_W-1:0] {
    LDW_CWGT = 4'd0,
    LDW_DWGT = 4'd1,
    LDW_STRT = 4'd2,
    LDW_CONT = 4'd3,
    LDW_MOVE = 4'd4
  } ldw_sel_e;

  // LIP sub-commands
  typedef enum logic [`AETHER_PARAM1_W-1:0] {
    LIP_STRT = 4'd0,
    LIP_CONT = 4'd1
  } lip_sel_e;

  // Memory command toward the memory datapath
  typedef enum logic [1:0] {
    MEM_IDLE  = 2'd0,
    MEM_WRITE = 2'd1,
    MEM_READ  = 2'd2
  } mem_cmd_e;

  // Captured host command
  typedef struct packed {
    instr_e                      instr;
    logic [`AETHER_PARAM1_W-1:0] param_1;
    logic [`AETHER_PARAM2_W-1:0] param_2;
  } cmd_t;

  // Register write request
  typedef struct packed {
    logic                        we;
    reg_addr_e                   addr;
    logic [`AETHER_PARAM2_W-1:0] data;
  } reg_wr_t;

  typedef struct packed {
    logic cwgt;
    logic conv;
    logic dwgt;
    logic dens;
    logic regs;
    logic full;
  } rst_cmd_t;

  typedef struct packed {
    logic cwgt;
    logic dwgt;
    logic strt;
    logic cont;
    logic move;
  } ldw_cmd_t;

  // Shared by convolution and dense
  typedef struct packed {
    logic                           run;
    logic [`AETHER_SAVE_ADDR_W-1:0] save_addr;
  } run_cmd_t;

  typedef struct packed {
    logic strt;
    logic cont;
  } lip_cmd_t;

endpackage

// File: hw/aether_register_file.sv
`timescale 1ns/1ns

`include "aether_consts.svh"

module aether_register_file (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  aether_pkg::reg_wr_t         reg_wr_i,
  input  aether_pkg::reg_addr_e       rd_sel_i,
  input  logic                        clear_i,
  input  logic                        err_i,
  output logic [`AETHER_PARAM2_W-1:0] rd_data_o
);

  // Slot of STATS in the writable bank
  localparam logic [2:0] STATS_IDX = 3'(aether_pkg::REG_STATS - aether_pkg::REG_MEMUP);

  // MEMUP to STATS, slot 0 is MEMUP
  logic [`AETHER_PARAM2_W-1:0] regs_q [8];

  logic       wr_ok;
  logic [2:0] wr_idx;
  logic       stats_wr;
  logic [2:0] rd_idx;

  // Only the writable window accepts a write
  assign wr_ok    = reg_wr_i.we && (reg_wr_i.addr >= aether_pkg::REG_MEMUP) &&
                    (reg_wr_i.addr <= aether_pkg::REG_STATS);
  assign wr_idx   = 3'(reg_wr_i.addr - aether_pkg::REG_MEMUP);
  assign stats_wr = wr_ok && (wr_idx == STATS_IDX);

  // ----------------------------------------------------------------------
  // Register bank update
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < 8; i++)
        regs_q[i] <= '0;
    end
    else
    begin
      // Bank clear from RST_REGS or RST_FULL
      if (clear_i)
      begin
        for (int i = 0; i < 8; i++)
          regs_q[i] <= '0;
      end
      if (wr_ok)
        regs_q[wr_idx] <= reg_wr_i.data;
      // Sticky error flag, host write to STATS takes precedence
      if (err_i && !stats_wr)
        regs_q[STATS_IDX][15] <= 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------------------

  assign rd_idx = 3'(rd_sel_i - aether_pkg::REG_MEMUP);

  always_comb
  begin
    if (rd_sel_i == aether_pkg::REG_VERSN)
      rd_data_o = `AETHER_VERSN_VALUE;
    else if (rd_sel_i == aether_pkg::REG_HWRID)
      rd_data_o = `AETHER_HWRID_VALUE;
    else if (rd_sel_i <= aether_pkg::REG_STATS)
      rd_data_o = regs_q[rd_idx];
    else
      rd_data_o = '0;
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f filelist.f \
  --top-module aether_tb -Mdir obj_dir -o aether_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/aether_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
echo "Pass message not found"
exit 1

// File: tb/aether_tb.sv
`timescale 1ns/1ns

`include "aether_consts.svh"

module aether_tb;

  // Room for one whitespace-separated token of the vectors file
  localparam int TOKW = 8 * 24;

  logic                        clk_i;
  logic                        rst_n_i;
  logic                        cmd_valid_i;
  logic [`AETHER_INSTR_W-1:0]  instr_i;
  logic [`AETHER_PARAM1_W-1:0] param_1_i;
  logic [`AETHER_PARAM2_W-1:0] param_2_i;
  logic [`AETHER_PARAM2_W-1:0] rdata_o;
  logic                        rdata_valid_o;
  aether_pkg::rst_cmd_t        rst_o;
  aether_pkg::ldw_cmd_t        ldw_o;
  aether_pkg::run_cmd_t        cnv_o;
  aether_pkg::run_cmd_t        dns_o;
  aether_pkg::lip_cmd_t        lip_o;
  aether_pkg::mem_cmd_e        mem_cmd_o;
  logic                        cmd_err_o;

  int                          fd;
  int                          vec_num;
  // Value rdata_o must hold between reads
  logic [`AETHER_PARAM2_W-1:0] last_rd;

  aether_engine_ctrl_top aether_engine_ctrl_top_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cmd_valid_i   (cmd_valid_i),
    .instr_i       (instr_i),
    .param_1_i     (param_1_i),
    .param_2_i     (param_2_i),
    .rdata_o       (rdata_o),
    .rdata_valid_o (rdata_valid_o),
    .rst_o         (rst_o),
    .ldw_o         (ldw_o),
    .cnv_o         (cnv_o),
    .dns_o         (dns_o),
    .lip_o         (lip_o),
    .mem_cmd_o     (mem_cmd_o),
    .cmd_err_o     (cmd_err_o)
  );

  // 4 ns period
  always #2 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // Reporting and compare
  // ----------------------------------------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected)
    begin
      abort_run($sformatf("Error: %s is 0x%h, expected 0x%h, vector %0d",
                          name, actual, expected, vec_num));
    end
  endtask

  // Word layout {rst, ldw, cnv, dns, lip, mem, err}, err in bit 0
  task automatic check_ctrl(input logic [59:0] ctrl);
    check_value("rst_o", 64'(rst_o), 64'(ctrl[57:52]));
    check_value("ldw_o", 64'(ldw_o), 64'(ctrl[51:47]));
    check_value("cnv_o", 64'(cnv_o), 64'(ctrl[46:26]));
    check_value("dns_o", 64'(dns_o), 64'(ctrl[25:5]));
    check_value("lip_o", 64'(lip_o), 64'(ctrl[4:3]));
    check_value("mem_cmd_o", 64'(mem_cmd_o), 64'(ctrl[2:1]));
    check_value("cmd_err_o", 64'(cmd_err_o), 64'(ctrl[0]));
  endtask

  // ----------------------------------------------------------------------
  // Vectors file parsing
  // ----------------------------------------------------------------------

  task automatic read_token(output logic [TOKW-1:0] tok, output int code);
    tok  = '0;
    code = $fscanf(fd, "%s", tok);
  endtask

  // Drops the rest of a comment line
  task automatic skip_line();
    int c;
    c = $fgetc(fd);
    while (c != 10 && c != -1)
      c = $fgetc(fd);
  endtask

  // Token text is right aligned, first character is the top non-zero byte
  function automatic logic [7:0] first_char(input logic [TOKW-1:0] tok);
    logic [7:0] c;
    c = 8'h00;
    for (int i = 0; i < TOKW / 8; i++)
    begin
      if (tok[8*i +: 8] != 8'h00)
        c = tok[8*i +: 8];
    end
    return c;
  endfunction

  // Bit 64 flags a character that is no hex digit
  function automatic logic [64:0] parse_hex(input logic [TOKW-1:0] tok);
    logic [63:0] val;
    logic        bad;
    logic [7:0]  c;
    val = '0;
    bad = 1'b0;
    for (int i = TOKW / 8 - 1; i >= 0; i--)
    begin
      c = tok[8*i +: 8];
      if (c >= "0" && c <= "9")
        val = {val[59:0], 4'(c - 8'h30)};
      else if (c >= "a" && c <= "f")
        val = {val[59:0], 4'(c - 8'h57)};
      else if (c >= "A" && c <= "F")
        val = {val[59:0], 4'(c - 8'h37)};
      else if (c != 8'h00)
        bad = 1'b1;
    end
    return {bad, val};
  endfunction

  // ----------------------------------------------------------------------
  // One command
  // ----------------------------------------------------------------------

  // Strobe, check the pulses of the decode cycle, then the read return
  task automatic run_vector(input logic [63:0] instr, input logic [63:0] p1,
                            input logic [63:0] p2, input logic [59:0] ctrl,
                            input logic is_read, input logic [15:0] rd_exp);
    int cycles;
    cmd_valid_i = 1'b1;
    instr_i     = instr[`AETHER_INSTR_W-1:0];
    param_1_i   = p1[`AETHER_PARAM1_W-1:0];
    param_2_i   = p2[`AETHER_PARAM2_W-1:0];
    @(posedge clk_i);
    #1;
    cmd_valid_i = 1'b0;
    check_ctrl(ctrl);
    // Read data of an earlier read still held
    check_value("rdata_valid_o", 64'(rdata_valid_o), 64'd0);
    check_value("rdata_o", 64'(rdata_o), 64'(last_rd));
    if (is_read)
    begin
      cycles = 0;
      while (!rdata_valid_o)
      begin
        if (cycles >= 10)
          abort_run("Timed out waiting for rdata_valid_o after a register read");
        @(posedge clk_i);
        #1;
        cycles++;
      end
      check_value("rdata_o", 64'(rdata_o), 64'(rd_exp));
      last_rd = rd_exp;
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial
  begin : main
    logic [TOKW-1:0] fields [5];
    logic [64:0]     parsed [4];
    logic [64:0]     rd_val;
    int              code;
    logic            done;
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    cmd_valid_i = 1'b0;
    instr_i     = '0;
    param_1_i   = '0;
    param_2_i   = '0;
    vec_num     = 0;
    last_rd     = '0;
    fd = $fopen("tb/aether_vectors.txt", "r");
    if (fd == 0)
      abort_run("Could not open the vectors file tb/aether_vectors.txt");
    // Reset for 4 cycles, release just after an edge
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    check_ctrl(60'd0);
    check_value("rdata_valid_o", 64'(rdata_valid_o), 64'd0);
    check_value("rdata_o", 64'(rdata_o), 64'd0);
    done = 1'b0;
    while (!done)
    begin
      read_token(fields[0], code);
      if (code != 1)
        done = 1'b1;
      else if (first_char(fields[0]) == "#")
        skip_line();
      else
      begin
        vec_num++;
        for (int k = 1; k < 5; k++)
        begin
          read_token(fields[k], code);
          if (code != 1)
            abort_run($sformatf("Vector %0d has fewer than five columns", vec_num));
        end
        for (int k = 0; k < 4; k++)
        begin
          parsed[k] = parse_hex(fields[k]);
          if (parsed[k][64])
            abort_run($sformatf("Vector %0d holds a column that is not hex", vec_num));
        end
        // Expected read value, x for no read
        if (fields[4][7:0] == "x" && fields[4][TOKW-1:8] == '0)
          run_vector(parsed[0][63:0], parsed[1][63:0], parsed[2][63:0],
                     parsed[3][59:0], 1'b0, 16'h0000);
        else
        begin
          rd_val = parse_hex(fields[4]);
          if (rd_val[64])
            abort_run($sformatf("Vector %0d has a bad read value", vec_num));
          run_vector(parsed[0][63:0], parsed[1][63:0], parsed[2][63:0],
                     parsed[3][59:0], 1'b1, rd_val[15:0]);
        end
      end
    end
    $fclose(fd);
    if (vec_num == 0)
      abort_run("The vectors file held no commands");
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: tb/aether_vectors.txt
# instr param_1 param_2 ctrl rdata, all hex, rdata is x for commands that are not reads
# ctrl packs {rst[5:0], ldw[4:0], cnv[20:0], dns[20:0], lip[1:0], mem[1:0], err}
2 0 0000 000000000000000 0102
2 1 0000 000000000000000 AE01
2 9 0000 000000000000000 0000
3 2 1111 000000000000000 x
3 3 2222 000000000000000 x
3 4 3333 000000000000000 x
3 5 4444 000000000000000 x
3 6 5555 000000000000000 x
3 7 6666 000000000000000 x
3 8 7777 000000000000000 x
3 9 0888 000000000000000 x
2 2 0000 000000000000000 1111
2 3 0000 000000000000000 2222
2 4 0000 000000000000000 3333
2 5 0000 000000000000000 4444
2 6 0000 000000000000000 5555
2 7 0000 000000000000000 6666
2 8 0000 000000000000000 7777
2 9 0000 000000000000000 0888
3 0 DEAD 000000000000001 x
2 0 0000 000000000000000 0102
2 9 0000 000000000000000 8888
2 C 0000 000000000000001 0000
1 1 0000 200000000000000 x
1 2 0000 100000000000000 x
1 3 0000 080000000000000 x
1 4 0000 040000000000000 x
1 5 0000 020000000000000 x
2 5 0000 000000000000000 0000
1 0 0000 3F0000000000000 x
1 A 0000 3F0000000000001 x
2 9 0000 000000000000000 8000
3 9 0000 000000000000000 x
4 0 0000 008000000000004 x
4 1 0000 004000000000004 x
4 2 0000 002000000000000 x
4 3 0000 001000000000000 x
4 4 0000 000800000000002 x
4 7 0000 000000000000001 x
7 0 0000 000000000000010 x
7 1 0000 000000000000008 x
7 5 0000 000000000000001 x
5 3 1234 0004C48D0000004 x
6 0 BEEF 00000000217DDE4 x
6 3 1111 000000000000005 x
C 2 FFFF 000000000000000 x
2 9 0000 000000000000000 8000
